/* Makefile */
VERILATOR ?= verilator
TOP       := tb_lsu
FILELIST  := tb.f
FLAGS     := --timing --assert
LOG       := sim.log
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and depth
  ////////////////////////////////////////////////////////////

  // Data and address width
  localparam int XLEN = 32;

  // Byte lanes in one bus word
  localparam int NUM_BYTES = 4;

  // Bus transfers allowed in flight at once
  localparam int MAX_OUTSTANDING = 2;

  // Outstanding counter width, one spare code above the maximum
  localparam int CNT_W = 2;

  ////////////////////////////////////////////////////////////
  // Access size
  ////////////////////////////////////////////////////////////

  // Encoding follows the core's funct3 size bits
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  ////////////////////////////////////////////////////////////
  // Stage structs
  ////////////////////////////////////////////////////////////

  // One load or store as issued from EX
  typedef struct packed {
    logic            we;
    lsu_size_e       size;
    logic            sext;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    // Store data, not yet rotated into lanes
    logic [XLEN-1:0] wdata;
  } lsu_req_t;

  // Address phase of one bus transfer
  typedef struct packed {
    logic [XLEN-1:0]      addr;
    logic                 we;
    logic [NUM_BYTES-1:0] be;
    logic [XLEN-1:0]      wdata;
  } bus_req_t;

  // Control carried from the address phase to the matching response
  typedef struct packed {
    lsu_size_e  size;
    logic       sext;
    logic       we;
    // Low address bits of the original access
    logic [1:0] offset;
    // Low only on the first transfer of a split
    logic       last;
  } wb_ctrl_t;

endpackage

`default_nettype wire

/* lsu_request_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module lsu_request_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  lsu_pkg::lsu_req_t lsu_req_i,
  input  logic              valid_0_i,
  input  logic              grant_ok_i,
  input  logic              ctrl_update_i,
  output logic              data_req_o,
  output lsu_pkg::bus_req_t bus_req_o,
  output logic              split_0_o,
  output lsu_pkg::wb_ctrl_t wb_ctrl_o
);

  import lsu_pkg::*;

  logic [XLEN-1:0]      addr;
  logic [1:0]           offset;
  logic                 split_q;
  logic [NUM_BYTES-1:0] size_mask;
  logic [NUM_BYTES-1:0] be;
  logic [2*XLEN-1:0]    wdata_dbl;

  ////////////////////////////////////////////////////////////
  // Address and split detection
  ////////////////////////////////////////////////////////////

  // Effective address, base plus offset
  assign addr   = lsu_req_i.op_a + lsu_req_i.op_b;
  assign offset = addr[1:0];

  // Only the first phase can start a split
  // A word off its boundary or a halfword in the top lane spills over
  always_comb begin
    split_0_o = 1'b0;
    if (valid_0_i && !split_q) begin
      case (lsu_req_i.size)
        SIZE_WORD: split_0_o = (offset != 2'b00);
        SIZE_HALF: split_0_o = (offset == 2'b11);
        default:   split_0_o = 1'b0;
      endcase
    end
  end

  // High during the second address phase of a split
  // Dropped when EX empties so the next access starts as a first phase
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!valid_0_i) begin
      split_q <= 1'b0;
    end else if (ctrl_update_i) begin
      split_q <= split_0_o;
    end
  end

  ////////////////////////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////////////////////////

  // Lanes covered by an aligned access of this size
  always_comb begin
    case (lsu_req_i.size)
      SIZE_BYTE: size_mask = 4'b0001;
      SIZE_HALF: size_mask = 4'b0011;
      default:   size_mask = 4'b1111;
    endcase
  end

  // First phase keeps the lanes from the offset upward
  // Second phase takes the lanes pushed out above lane 3
  always_comb begin
    if (split_q) begin
      be = size_mask >> (NUM_BYTES - offset);
    end else begin
      be = size_mask << offset;
    end
  end

  ////////////////////////////////////////////////////////////
  // Write data and bus request
  ////////////////////////////////////////////////////////////

  // Rotate left by the byte offset, so both phases share one word
  assign wdata_dbl = {lsu_req_i.wdata, lsu_req_i.wdata} << (8 * offset);

  always_comb begin
    // Second phase goes to the next word, lane 0 upward
    if (split_q) begin
      bus_req_o.addr = {addr[XLEN-1:2], 2'b00} + XLEN'(NUM_BYTES);
    end else begin
      bus_req_o.addr = addr;
    end
    bus_req_o.we    = lsu_req_i.we;
    bus_req_o.be    = be;
    bus_req_o.wdata = wdata_dbl[2*XLEN-1:XLEN];
  end

  // Request only while a slot is free in the tracker
  assign data_req_o = valid_0_i && grant_ok_i;

  // Control that follows this transfer to WB
  always_comb begin
    wb_ctrl_o.size   = lsu_req_i.size;
    wb_ctrl_o.sext   = lsu_req_i.sext;
    wb_ctrl_o.we     = lsu_req_i.we;
    wb_ctrl_o.offset = offset;
    wb_ctrl_o.last   = !split_0_o;
  end

  // A request left waiting for a grant must not change or drop
  a_req_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    data_req_o && !ctrl_update_i |=> data_req_o && $stable(bus_req_o)
  );

endmodule

`default_nettype wire

/* lsu_response_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module lsu_response_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     data_rvalid_i,
  input  logic [lsu_pkg::XLEN-1:0] data_rdata_i,
  input  lsu_pkg::wb_ctrl_t        head_ctrl_i,
  output logic                     valid_1_o,
  output logic                     last_1_o,
  output logic                     we_1_o,
  output logic [lsu_pkg::XLEN-1:0] rdata_1_o
);

  import lsu_pkg::*;

  logic [XLEN-1:0]   rdata_q;
  logic              first_half_q;
  logic              first_we_q;
  logic              rdata_is_split;
  logic [2*XLEN-1:0] rdata_full;
  logic [2*XLEN-1:0] rdata_aligned;

  ////////////////////////////////////////////////////////////
  // Response handshake
  ////////////////////////////////////////////////////////////

  // Every response is reported, split halves included
  assign valid_1_o = data_rvalid_i;
  assign last_1_o  = head_ctrl_i.last;
  assign we_1_o    = head_ctrl_i.we;

  ////////////////////////////////////////////////////////////
  // Split capture
  ////////////////////////////////////////////////////////////

  // Low word of a split load, kept until the upper word returns
  always_ff @(posedge clk) begin
    if (data_rvalid_i && !head_ctrl_i.we && !head_ctrl_i.last) begin
      rdata_q <= data_rdata_i;
    end
  end

  // Tracks an open split between its two responses
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_half_q <= 1'b0;
      first_we_q   <= 1'b0;
    end else if (data_rvalid_i) begin
      first_half_q <= !head_ctrl_i.last;
      first_we_q   <= head_ctrl_i.we;
    end
  end

  ////////////////////////////////////////////////////////////
  // Realign and extend
  ////////////////////////////////////////////////////////////

  // Same split rule as in EX, seen from the stored control
  assign rdata_is_split = ((head_ctrl_i.size == SIZE_WORD) && (head_ctrl_i.offset != 2'b00)) ||
                          ((head_ctrl_i.size == SIZE_HALF) && (head_ctrl_i.offset == 2'b11));

  // Unsplit case doubles the word so the shift wraps it around
  assign rdata_full = rdata_is_split ? {data_rdata_i, rdata_q} :
                                       {data_rdata_i, data_rdata_i};

  // Bring the addressed byte down to lane 0
  assign rdata_aligned = rdata_full >> (8 * head_ctrl_i.offset);

  always_comb begin
    case (head_ctrl_i.size)
      SIZE_BYTE: begin
        rdata_1_o = {{(XLEN-8){head_ctrl_i.sext && rdata_aligned[7]}},
                     rdata_aligned[7:0]};
      end
      SIZE_HALF: begin
        rdata_1_o = {{(XLEN-16){head_ctrl_i.sext && rdata_aligned[15]}},
                     rdata_aligned[15:0]};
      end
      default: begin
        rdata_1_o = rdata_aligned[XLEN-1:0];
      end
    endcase
  end

  // Second response of a split is the last of the same access
  a_split_pair: assert property (
    @(posedge clk) disable iff (!rst_n)
    data_rvalid_i && first_half_q |-> head_ctrl_i.last && (head_ctrl_i.we == first_we_q)
  );

endmodule

`default_nettype wire

/* lsu_top.sv */
`default_nettype none
`timescale 1ns/1ps

module lsu_top (
  input  logic                     clk,
  input  logic                     rst_n,

  // EX side
  input  lsu_pkg::lsu_req_t        lsu_req_i,
  input  logic                     valid_0_i,
  output logic                     ready_0_o,

  // Data bus, address phase
  output lsu_pkg::bus_req_t        bus_req_o,
  output logic                     data_req_o,
  input  logic                     data_gnt_i,

  // Data bus, response phase
  input  logic                     data_rvalid_i,
  input  logic [lsu_pkg::XLEN-1:0] data_rdata_i,

  // WB side
  output logic                     valid_1_o,
  output logic [lsu_pkg::XLEN-1:0] rdata_1_o,
  output logic                     last_1_o,
  output logic                     we_1_o,

  output logic                     busy_o
);

  import lsu_pkg::*;

  logic     grant_ok;
  logic     ctrl_update;
  logic     split_0;
  wb_ctrl_t wb_ctrl;
  wb_ctrl_t head_ctrl;

  ////////////////////////////////////////////////////////////
  // EX stage
  ////////////////////////////////////////////////////////////

  lsu_request_stage u_request (
    .clk           (clk),
    .rst_n         (rst_n),
    .lsu_req_i     (lsu_req_i),
    .valid_0_i     (valid_0_i),
    .grant_ok_i    (grant_ok),
    .ctrl_update_i (ctrl_update),
    .data_req_o    (data_req_o),
    .bus_req_o     (bus_req_o),
    .split_0_o     (split_0),
    .wb_ctrl_o     (wb_ctrl)
  );

  // Counter and control queue between the two stages
  lsu_txn_tracker u_tracker (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_req_i    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .valid_0_i     (valid_0_i),
    .split_0_i     (split_0),
    .wb_ctrl_i     (wb_ctrl),
    .grant_ok_o    (grant_ok),
    .ctrl_update_o (ctrl_update),
    .ready_0_o     (ready_0_o),
    .busy_o        (busy_o),
    .head_ctrl_o   (head_ctrl)
  );

  ////////////////////////////////////////////////////////////
  // WB stage
  ////////////////////////////////////////////////////////////

  lsu_response_stage u_response (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .head_ctrl_i   (head_ctrl),
    .valid_1_o     (valid_1_o),
    .last_1_o      (last_1_o),
    .we_1_o        (we_1_o),
    .rdata_1_o     (rdata_1_o)
  );

endmodule

`default_nettype wire

/* lsu_txn_tracker.sv */
`default_nettype none
`timescale 1ns/1ps

module lsu_txn_tracker (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              data_req_i,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  input  logic              valid_0_i,
  input  logic              split_0_i,
  input  lsu_pkg::wb_ctrl_t wb_ctrl_i,
  output logic              grant_ok_o,
  output logic              ctrl_update_o,
  output logic              ready_0_o,
  output logic              busy_o,
  output lsu_pkg::wb_ctrl_t head_ctrl_o
);

  import lsu_pkg::*;

  logic [CNT_W-1:0]                   cnt_q;
  logic [CNT_W-1:0]                   cnt_d;
  logic                               count_up;
  logic                               count_down;
  wb_ctrl_t                           queue_q [MAX_OUTSTANDING];
  logic [$clog2(MAX_OUTSTANDING)-1:0] wr_ptr_q;
  logic [$clog2(MAX_OUTSTANDING)-1:0] rd_ptr_q;

  ////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////

  // Address phase accepted by the bus
  assign ctrl_update_o = data_req_i && data_gnt_i;

  // Room for one more transfer
  assign grant_ok_o = (cnt_q < CNT_W'(MAX_OUTSTANDING));

  // EX moves on once its last phase is granted
  assign ready_0_o = !valid_0_i || (ctrl_update_o && !split_0_i);

  assign busy_o = data_req_i || (cnt_q != '0);

  ////////////////////////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////////////////////////

  assign count_up   = ctrl_update_o;
  assign count_down = data_rvalid_i;

  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  // Queue pointers share the counter's reset and timing
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q    <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      cnt_q <= cnt_d;
      if (count_up) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (count_down) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // WB control, one slot per transfer in flight
  always_ff @(posedge clk) begin
    if (count_up) begin
      queue_q[wr_ptr_q] <= wb_ctrl_i;
    end
  end

  // Oldest transfer, matches the next in-order response
  assign head_ctrl_o = queue_q[rd_ptr_q];

  a_cnt_bound: assert property (
    @(posedge clk) disable iff (!rst_n)
    cnt_q <= CNT_W'(MAX_OUTSTANDING)
  );

  // Every response belongs to an earlier grant
  a_no_orphan_rsp: assert property (
    @(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> cnt_q != '0
  );

endmodule

`default_nettype wire

/* tb.f */
lsu_pkg.sv
lsu_request_stage.sv
lsu_txn_tracker.sv
lsu_response_stage.sv
lsu_top.sv
tb_data_mem.sv
tb_lsu.sv

/* tb_data_mem.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_data_mem (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req_i,
  input  lsu_pkg::bus_req_t        bus_req_i,
  output logic                     gnt_o,
  output logic                     rvalid_o,
  output logic [lsu_pkg::XLEN-1:0] rdata_o
);

  import lsu_pkg::*;

  localparam int DEPTH = 256;

  logic [XLEN-1:0] mem [DEPTH];
  // Pending responses, oldest first, with the cycle each one is due
  logic [XLEN-1:0] rsp_data_q [$];
  int              rsp_due_q [$];
  int              cyc;
  int              gnt_wait;
  int              idx;

  // Every byte of the fill depends on the full word index
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = {8'(i), 8'(i ^ 'h5a), 8'(i * 7 + 3), 8'(~i)};
    end
    cyc      = 0;
    gnt_wait = 0;
    gnt_o    = 1'b1;
    rvalid_o = 1'b0;
    rdata_o  = '0;
  end

  always @(posedge clk) begin
    cyc++;
    if (rst_n && req_i && gnt_o) begin
      idx = int'(bus_req_i.addr[9:2]);
      // Writes honour the byte enables
      if (bus_req_i.we) begin
        for (int b = 0; b < NUM_BYTES; b++) begin
          if (bus_req_i.be[b]) begin
            mem[idx][8*b +: 8] = bus_req_i.wdata[8*b +: 8];
          end
        end
      end
      rsp_data_q.push_back(mem[idx]);
      // Response 1 to 3 cycles after the grant
      rsp_due_q.push_back(cyc + int'($urandom_range(1, 3)) - 1);
      gnt_wait = int'($urandom_range(0, 2));
    end else if (req_i && gnt_wait > 0) begin
      gnt_wait--;
    end
    #1;
    gnt_o = (gnt_wait == 0);
    // One response per cycle keeps the order
    if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
      void'(rsp_due_q.pop_front());
      rdata_o  = rsp_data_q.pop_front();
      rvalid_o = 1'b1;
    end else begin
      rvalid_o = 1'b0;
      rdata_o  = '0;
    end
  end

endmodule

`default_nettype wire

/* tb_lsu.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_lsu;

  import lsu_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int NUM_ACCESSES = 68;
  localparam int MAX_CYCLES   = 40 * NUM_ACCESSES + 100;

  logic            clk;
  logic            rst_n;
  lsu_req_t        lsu_req;
  logic            valid_0;
  logic            ready_0;
  bus_req_t        bus_req;
  logic            data_req;
  logic            data_gnt;
  logic            data_rvalid;
  logic [XLEN-1:0] data_rdata;
  logic            valid_1;
  logic [XLEN-1:0] rdata_1;
  logic            last_1;
  logic            we_1;
  logic            busy;

  // Reference byte memory and expected traffic
  logic [7:0]        ref_bytes [1024];
  bus_req_t          exp_bus_q [$];
  logic [XLEN+1:0]   exp_rsp_q [$];
  int                err_cnt;
  int                chk_cnt;
  int                test_cnt;
  int                cyc_cnt;
  int                outstanding;

  lsu_top dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .lsu_req_i     (lsu_req),
    .valid_0_i     (valid_0),
    .ready_0_o     (ready_0),
    .bus_req_o     (bus_req),
    .data_req_o    (data_req),
    .data_gnt_i    (data_gnt),
    .data_rvalid_i (data_rvalid),
    .data_rdata_i  (data_rdata),
    .valid_1_o     (valid_1),
    .rdata_1_o     (rdata_1),
    .last_1_o      (last_1),
    .we_1_o        (we_1),
    .busy_o        (busy)
  );

  tb_data_mem u_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (data_req),
    .bus_req_i (bus_req),
    .gnt_o     (data_gnt),
    .rvalid_o  (data_rvalid),
    .rdata_o   (data_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] exp);
    err_cnt++;
    $display("[ERROR] %s: got %h, expected %h", name, got, exp);
  endtask

  task automatic report_fault(input string what);
    err_cnt++;
    $display("Error at cycle %0d: %s", cyc_cnt, what);
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    $display("test %0s finished, %0d errors so far", name, err_cnt);
  endtask

  // Builds the expected bus traffic from single bytes, then drives EX
  task automatic issue(input logic we, input lsu_size_e size, input logic sext,
                       input logic [XLEN-1:0] addr, input logic [XLEN-1:0] wdata);
    int              n;
    int              ba;
    int              off_b;
    logic [3:0]      be0;
    logic [3:0]      be1;
    logic [XLEN-1:0] wd0;
    logic [XLEN-1:0] wd1;
    logic [XLEN-1:0] val;
    logic [XLEN-1:0] split_b;
    logic [XLEN-1:0] addr1;
    bus_req_t        r;
    n     = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
    be0   = '0;
    be1   = '0;
    wd0   = '0;
    wd1   = '0;
    val   = '0;
    addr1 = '0;
    for (int i = 0; i < n; i++) begin
      ba = int'(addr[9:0]) + i;
      // Bytes past the word boundary belong to the second transfer
      if ((ba >> 2) == int'(addr[9:2])) begin
        be0[ba % 4]          = 1'b1;
        wd0[8*(ba % 4) +: 8] = wdata[8*i +: 8];
      end else begin
        // Second transfer starts at the first byte past the boundary
        if (be1 == '0) addr1 = addr + XLEN'(i);
        be1[ba % 4]          = 1'b1;
        wd1[8*(ba % 4) +: 8] = wdata[8*i +: 8];
      end
      if (we) begin
        ref_bytes[ba] = wdata[8*i +: 8];
      end else begin
        val[8*i +: 8] = ref_bytes[ba];
      end
    end
    if (sext && n == 1) val = {{24{val[7]}}, val[7:0]};
    if (sext && n == 2) val = {{16{val[15]}}, val[15:0]};
    r = '{addr: addr, we: we, be: be0, wdata: wd0};
    exp_bus_q.push_back(r);
    if (be1 != '0) begin
      r = '{addr: addr1, we: we, be: be1, wdata: wd1};
      exp_bus_q.push_back(r);
      exp_rsp_q.push_back({1'b0, we, 32'h0});
    end
    exp_rsp_q.push_back({1'b1, we, val});
    // Random split of the address between the two operands
    off_b           = int'($urandom_range(0, 16));
    split_b         = XLEN'(off_b);
    lsu_req.we      = we;
    lsu_req.size    = size;
    lsu_req.sext    = sext;
    lsu_req.op_a    = addr - split_b;
    lsu_req.op_b    = split_b;
    lsu_req.wdata   = wdata;
    valid_0         = 1'b1;
    @(posedge clk);
    while (!ready_0) @(posedge clk);
    #1;
    // EX may only move on once every transfer of the access was granted
    assert (exp_bus_q.size() == 0)
      else report_fault("ready_0_o high before every transfer of the access was granted");
  endtask

  task automatic idle_and_drain();
    valid_0 = 1'b0;
    while (exp_rsp_q.size() != 0 || outstanding != 0) @(posedge clk);
    #1;
  endtask

  ////////////////////////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////////////////////////

  // Bus requests against the byte model, enabled lanes only for data
  always @(posedge clk) begin
    bus_req_t        e;
    logic [XLEN-1:0] lane_mask;
    if (rst_n && data_req && data_gnt) begin
      if (exp_bus_q.size() == 0) begin
        report_fault("bus request granted with none expected");
      end else begin
        e         = exp_bus_q.pop_front();
        lane_mask = {{8{e.be[3]}}, {8{e.be[2]}}, {8{e.be[1]}}, {8{e.be[0]}}};
        chk_cnt++;
        assert (bus_req.addr == e.addr)
          else report_mismatch("bus_req_o.addr", bus_req.addr, e.addr);
        assert (bus_req.be == e.be)
          else report_mismatch("bus_req_o.be", 32'(bus_req.be), 32'(e.be));
        assert (bus_req.we == e.we)
          else report_mismatch("bus_req_o.we", 32'(bus_req.we), 32'(e.we));
        if (e.we) begin
          assert ((bus_req.wdata & lane_mask) == e.wdata)
            else report_mismatch("bus_req_o.wdata", bus_req.wdata & lane_mask, e.wdata);
        end
      end
    end
  end

  // Responses in order, read data only on the last half of a load
  always @(posedge clk) begin
    logic [XLEN+1:0] e;
    if (rst_n && valid_1) begin
      if (exp_rsp_q.size() == 0) begin
        report_fault("response seen with none expected");
      end else begin
        e = exp_rsp_q.pop_front();
        chk_cnt++;
        assert (last_1 == e[XLEN+1])
          else report_mismatch("last_1_o", 32'(last_1), 32'(e[XLEN+1]));
        assert (we_1 == e[XLEN])
          else report_mismatch("we_1_o", 32'(we_1), 32'(e[XLEN]));
        if (e[XLEN+1] && !e[XLEN]) begin
          assert (rdata_1 == e[XLEN-1:0])
            else report_mismatch("rdata_1_o", rdata_1, e[XLEN-1:0]);
        end
      end
    end
  end

  // Granted transfers still waiting for a response
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(data_req && data_gnt) - int'(data_rvalid);
    end
  end

  a_reset_idle: assert property (
    @(posedge clk) $rose(rst_n) |-> !data_req && !valid_1 && !busy && ready_0
  ) else report_fault("outputs not idle after reset");

  a_req_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    data_req && !data_gnt |=> data_req && $stable(bus_req)
  ) else report_fault("bus request changed while waiting for a grant");

  a_max_outstanding: assert property (
    @(posedge clk) disable iff (!rst_n) outstanding <= MAX_OUTSTANDING
  ) else report_fault("more than two transfers in flight");

  a_busy: assert property (
    @(posedge clk) disable iff (!rst_n) outstanding != 0 |-> busy
  ) else report_fault("busy_o low with a transfer outstanding");

  // Run limit from the number of accesses
  always @(posedge clk) begin
    cyc_cnt++;
    if (cyc_cnt >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles", cyc_cnt);
      $display("TEST FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h3934));
    err_cnt  = 0;
    chk_cnt  = 0;
    test_cnt = 0;
    cyc_cnt  = 0;
    rst_n    = 1'b0;
    valid_0  = 1'b0;
    lsu_req  = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < 1024; i++) begin
      ref_bytes[i] = u_mem.mem[i / 4][8*(i % 4) +: 8];
    end
    @(posedge clk);
    #1;
    finish_test("reset");

    for (int i = 0; i < 8; i++) issue(1'b1, SIZE_WORD, 1'b0, 32'h40 + 4 * i, $urandom);
    for (int i = 0; i < 8; i++) issue(1'b0, SIZE_WORD, 1'b0, 32'h40 + 4 * i, '0);
    idle_and_drain();
    finish_test("aligned words");

    // Bytes and halves at every offset, each in its own word
    for (int off = 0; off < 4; off++) begin
      issue(1'b1, SIZE_BYTE, 1'b0, 32'h100 + 4 * off + off, $urandom);
      issue(1'b1, SIZE_HALF, 1'b0, 32'h120 + 8 * off + off, $urandom);
    end
    for (int s = 0; s < 2; s++) begin
      for (int off = 0; off < 4; off++) begin
        issue(1'b0, SIZE_BYTE, s[0], 32'h100 + 4 * off + off, '0);
        issue(1'b0, SIZE_HALF, s[0], 32'h120 + 8 * off + off, '0);
      end
    end
    idle_and_drain();
    finish_test("bytes and halves");

    for (int off = 1; off < 4; off++) begin
      issue(1'b1, SIZE_WORD, 1'b0, 32'h200 + 8 * off + off, $urandom);
    end
    issue(1'b1, SIZE_HALF, 1'b0, 32'h233, $urandom);
    for (int off = 1; off < 4; off++) begin
      issue(1'b0, SIZE_WORD, 1'b0, 32'h200 + 8 * off + off, '0);
    end
    issue(1'b0, SIZE_HALF, 1'b1, 32'h233, '0);
    idle_and_drain();
    finish_test("split accesses");

    // Back-to-back loads under random bus delays
    for (int i = 0; i < 20; i++) begin
      issue(1'b0, SIZE_WORD, 1'b0, {22'h0, 8'($urandom_range(0, 254)), 2'b00}, '0);
    end
    idle_and_drain();
    finish_test("back-to-back loads");

    $display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
